// File: src/i2c_cmd_pkg.sv
`default_nettype none

package i2c_cmd_pkg;

  // Host command address and command/response word
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_word_t;

  // Command addresses decoded by the sequencer
  localparam cmd_addr_t CMD_ADDR_BUS1   = 6'h3c;
  localparam cmd_addr_t CMD_ADDR_BUS2   = 6'h3d;
  localparam cmd_addr_t CMD_ADDR_FILTER = 6'h00;

  // Tag in bits 31..25 of a direct command
  localparam logic [6:0] CMD_TAG = 7'h03;

  typedef enum logic [3:0] {
    IDLE,
    ADDR,
    WR_REG,
    WR_VAL,
    WR_PAD,
    RD_ADDR,
    RD_REG,
    RD_BYTE,
    DONE
  } seq_state_t;

endpackage

`default_nettype wire

// File: src/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

  typedef logic [6:0] dev_addr_t;
  typedef logic [7:0] i2c_byte_t;

  // Port expander behind the filter board
  localparam dev_addr_t EXPANDER_ADDR = 7'h20;
  localparam i2c_byte_t EXPANDER_REG  = 8'h0a;

  typedef enum logic [2:0] {
    IDLE,
    START,
    BIT,
    ACK,
    STOP,
    RESTART
  } phase_t;

endpackage

`default_nettype wire

// File: src/i2c_byte_if.sv
`timescale 1ns/10ps
`default_nettype none

interface i2c_byte_if import i2c_bus_pkg::*; ();

  dev_addr_t dev_addr;
  logic      op_write;
  logic      op_read;
  logic      op_stop;
  logic      op_valid;
  logic      op_ready;
  i2c_byte_t wr_data;
  logic      wr_valid;
  logic      wr_ready;
  i2c_byte_t rd_data;
  logic      rd_valid;
  logic      nack;
  logic      busy;

  modport seq (
    output dev_addr, op_write, op_read, op_stop, op_valid, wr_data, wr_valid,
    input  op_ready, wr_ready, rd_data, rd_valid, nack, busy
  );

  modport eng (
    input  dev_addr, op_write, op_read, op_stop, op_valid, wr_data, wr_valid,
    output op_ready, wr_ready, rd_data, rd_valid, nack, busy
  );

endinterface

`default_nettype wire

// File: src/i2c_cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_cmd_sequencer import i2c_cmd_pkg::*, i2c_bus_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  cmd_addr_t   cmd_addr_i,
  input  cmd_word_t   cmd_data_i,
  input  wire         cmd_rqst_i,
  output logic        cmd_ack_o,
  output cmd_word_t   cmd_resp_o,
  output logic        read_done_o,
  output logic        en_i2c2_o,
  output logic        ready_o,
  i2c_byte_if.seq     bus
);

  seq_state_t state;
  dev_addr_t  dev_q;
  i2c_byte_t  reg_q;
  i2c_byte_t  val_q;
  logic       is_read;
  logic       is_filter;
  logic [6:0] filt_q;
  logic       ant_q;
  logic [1:0] rd_cnt;

  logic direct_hit;
  logic filter_hit;
  logic need_bus;
  logic accept;
  logic drop;
  logic op_fire;
  logic wr_fire;

  assign direct_hit = ((cmd_addr_i == CMD_ADDR_BUS1) || (cmd_addr_i == CMD_ADDR_BUS2)) &&
                      (cmd_data_i[31:25] == CMD_TAG);
  // Filter bits 23..17, antenna bit 13
  assign filter_hit = (cmd_addr_i == CMD_ADDR_FILTER) &&
                      ((cmd_data_i[23:17] != filt_q) || (cmd_data_i[13] != ant_q));
  assign need_bus   = cmd_rqst_i && (direct_hit || filter_hit);
  assign accept     = need_bus && (state == i2c_cmd_pkg::IDLE) && !bus.busy;
  assign drop       = need_bus && !accept;

  assign op_fire = bus.op_valid && bus.op_ready;
  assign wr_fire = bus.wr_valid && bus.wr_ready;

  assign bus.dev_addr = dev_q;
  assign bus.op_write = (state == ADDR);
  assign bus.op_read  = (state == RD_ADDR);
  assign bus.op_valid = (state == ADDR) || (state == RD_ADDR);
  assign bus.wr_valid = (state == WR_REG) || (state == WR_VAL) ||
                        (state == WR_PAD) || (state == RD_REG);
  // Marks the last byte of the transaction
  assign bus.op_stop  = ((state == WR_VAL) && !is_filter) || (state == WR_PAD) ||
                        ((state == RD_BYTE) && (rd_cnt == 2'd3));

  always_comb begin
    case (state)
      WR_VAL:  bus.wr_data = val_q;
      WR_PAD:  bus.wr_data = 8'h00;
      default: bus.wr_data = reg_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= i2c_cmd_pkg::IDLE;
      is_read     <= 1'b0;
      is_filter   <= 1'b0;
      filt_q      <= '0;
      ant_q       <= 1'b0;
      rd_cnt      <= '0;
      cmd_ack_o   <= 1'b0;
      read_done_o <= 1'b0;
      en_i2c2_o   <= 1'b0;
      ready_o     <= 1'b0;
    end else begin
      read_done_o <= 1'b0;
      cmd_ack_o   <= (state == i2c_cmd_pkg::IDLE) && !bus.busy && !drop;
      ready_o     <= (state == i2c_cmd_pkg::IDLE) && !bus.busy;
      case (state)
        i2c_cmd_pkg::IDLE: begin
          if (accept) begin
            state <= ADDR;
            if (direct_hit) begin
              is_read   <= cmd_data_i[24];
              is_filter <= 1'b0;
              en_i2c2_o <= (cmd_addr_i == CMD_ADDR_BUS2);
            end else begin
              is_read   <= 1'b0;
              is_filter <= 1'b1;
              filt_q    <= cmd_data_i[23:17];
              ant_q     <= cmd_data_i[13];
              en_i2c2_o <= 1'b0;
            end
          end
        end
        ADDR:    if (op_fire) state <= is_read ? RD_REG : WR_REG;
        WR_REG:  if (wr_fire) state <= WR_VAL;
        WR_VAL:  if (wr_fire) state <= is_filter ? WR_PAD : DONE;
        WR_PAD:  if (wr_fire) state <= DONE;
        RD_REG:  if (wr_fire) state <= RD_ADDR;
        RD_ADDR: begin
          if (op_fire) begin
            rd_cnt <= '0;
            state  <= RD_BYTE;
          end
        end
        RD_BYTE: begin
          if (bus.rd_valid) begin
            rd_cnt <= rd_cnt + 2'd1;
            if (rd_cnt == 2'd3) begin
              read_done_o <= 1'b1;
              state       <= DONE;
            end
          end
        end
        DONE:    if (!bus.busy) state <= i2c_cmd_pkg::IDLE;
        default: state <= i2c_cmd_pkg::IDLE;
      endcase
    end
  end

  // Command payload and response
  always_ff @(posedge clk) begin
    if (accept) begin
      if (direct_hit) begin
        dev_q <= cmd_data_i[22:16];
        reg_q <= cmd_data_i[15:8];
        val_q <= cmd_data_i[7:0];
      end else begin
        dev_q <= EXPANDER_ADDR;
        reg_q <= EXPANDER_REG;
        val_q <= {cmd_data_i[13], cmd_data_i[23:17]};
      end
    end
    // First byte ends up lowest
    if ((state == RD_BYTE) && bus.rd_valid) begin
      cmd_resp_o <= {bus.rd_data, cmd_resp_o[31:8]};
    end
  end

  // Write byte held steady until the engine takes it
  a_wr_hold: assert property (@(posedge clk) disable iff (rst)
    (bus.wr_valid && !bus.wr_ready) |=> (bus.wr_valid && $stable(bus.wr_data)));

endmodule

`default_nettype wire

// File: src/i2c_bit_timer.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_timer #(
  parameter int PRESCALE = 2
) (
  input  wire        clk,
  input  wire        rst,
  input  wire        run_i,
  output logic       tick_o,
  output logic [1:0] quarter_o
);

  localparam int CW = (PRESCALE > 0) ? $clog2(PRESCALE + 1) : 1;

  logic [CW-1:0] cnt;

  assign tick_o = run_i && (cnt == CW'(PRESCALE));

  // Restart from quarter 0 whenever the engine goes idle
  always_ff @(posedge clk) begin
    if (rst || !run_i) begin
      cnt       <= '0;
      quarter_o <= 2'd0;
    end else if (tick_o) begin
      cnt       <= '0;
      quarter_o <= quarter_o + 2'd1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Steady ticking every PRESCALE+1 clocks
  a_tick_period: assert property (@(posedge clk) disable iff (rst)
    (tick_o && $past(run_i, PRESCALE + 1)) |-> $past(tick_o, PRESCALE + 1));

endmodule

`default_nettype wire

// File: src/i2c_byte_master.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_master import i2c_bus_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  i2c_byte_if.eng    bus,
  input  wire        tick_i,
  input  wire  [1:0] quarter_i,
  output logic       run_o,
  input  wire        scl_i,
  output logic       scl_o,
  output logic       scl_t,
  input  wire        sda_i,
  output logic       sda_o,
  output logic       sda_t
);

  phase_t     phase;
  logic [8:0] sh;
  logic [2:0] bit_cnt;
  logic       active;
  logic       reading;
  logic       addr_byte;
  logic       last_q;
  logic       samp;
  logic       scl_q;
  logic       sda_q;
  logic       nack_q;
  logic       rd_valid_q;
  i2c_byte_t  rd_data_q;

  assign run_o        = (phase != IDLE);
  assign bus.op_ready = (phase == IDLE);
  assign bus.wr_ready = (phase == IDLE) && active;
  assign bus.busy     = active;
  assign bus.nack     = nack_q;
  assign bus.rd_valid = rd_valid_q;
  assign bus.rd_data  = rd_data_q;

  // Open drain, a high level releases the line
  assign scl_o = scl_q;
  assign scl_t = scl_q;
  assign sda_o = sda_q;
  assign sda_t = sda_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= IDLE;
      bit_cnt    <= '0;
      active     <= 1'b0;
      reading    <= 1'b0;
      addr_byte  <= 1'b0;
      last_q     <= 1'b0;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      nack_q     <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= 1'b0;
      case (phase)
        IDLE: begin
          if (bus.op_valid) begin
            reading   <= bus.op_read;
            addr_byte <= 1'b1;
            last_q    <= bus.op_stop;
            bit_cnt   <= '0;
            active    <= 1'b1;
            phase     <= active ? RESTART : START;
            if (!active) nack_q <= 1'b0;
          end else if (active && bus.wr_valid) begin
            addr_byte <= 1'b0;
            last_q    <= bus.op_stop;
            bit_cnt   <= '0;
            phase     <= BIT;
          end
        end
        START, RESTART: begin
          if (tick_i) begin
            case (quarter_i)
              2'd0: sda_q <= 1'b1;
              2'd1: scl_q <= 1'b1;
              2'd2: sda_q <= 1'b0;
              default: begin
                scl_q <= 1'b0;
                phase <= BIT;
              end
            endcase
          end
        end
        BIT: begin
          if (tick_i) begin
            case (quarter_i)
              2'd0: sda_q <= sh[8];
              2'd1: scl_q <= 1'b1;
              2'd2: samp  <= sda_i;
              default: begin
                scl_q   <= 1'b0;
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) phase <= ACK;
              end
            endcase
          end
        end
        ACK: begin
          if (tick_i) begin
            case (quarter_i)
              2'd0: begin
                // NACK the final read byte
                if (reading && !addr_byte) begin
                  sda_q  <= bus.op_stop;
                  last_q <= bus.op_stop;
                end else begin
                  sda_q <= 1'b1;
                end
              end
              2'd1: scl_q <= 1'b1;
              2'd2: samp  <= sda_i;
              default: begin
                scl_q <= 1'b0;
                if (reading && !addr_byte) begin
                  rd_valid_q <= 1'b1;
                  rd_data_q  <= sh[7:0];
                end else if (samp) begin
                  nack_q <= 1'b1;
                end
                if (reading) begin
                  if (!addr_byte && last_q) begin
                    phase <= STOP;
                  end else begin
                    addr_byte <= 1'b0;
                    bit_cnt   <= '0;
                    phase     <= BIT;
                  end
                end else begin
                  phase <= last_q ? STOP : IDLE;
                end
              end
            endcase
          end
        end
        STOP: begin
          if (tick_i) begin
            case (quarter_i)
              2'd0: sda_q <= 1'b0;
              2'd1: scl_q <= 1'b1;
              2'd2: sda_q <= 1'b1;
              default: begin
                active <= 1'b0;
                phase  <= IDLE;
              end
            endcase
          end
        end
        default: phase <= IDLE;
      endcase
    end
  end

  // Shift register: transmit MSB first, receive into the low bits
  always_ff @(posedge clk) begin
    if ((phase == IDLE) && bus.op_valid) begin
      sh <= {bus.dev_addr, bus.op_read, 1'b1};
    end else if ((phase == IDLE) && active && bus.wr_valid) begin
      sh <= {bus.wr_data, 1'b1};
    end else if ((phase == BIT) && tick_i && (quarter_i == 2'd3)) begin
      sh <= {sh[7:0], samp};
    end else if ((phase == ACK) && tick_i && (quarter_i == 2'd3) && reading) begin
      sh <= 9'h1ff;
    end
  end

  a_sda_stable: assert property (@(posedge clk) disable iff (rst)
    ($changed(sda_o) && !(phase inside {START, RESTART, STOP})) |-> !scl_o);

  // Clock stretching is not supported, SCL readback is only watched
  a_scl_follow: assert property (@(posedge clk) disable iff (rst)
    (!scl_o && $past(!scl_o)) |-> !scl_i);

endmodule

`default_nettype wire

// File: src/i2c_bus_top.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_bus_top import i2c_cmd_pkg::*; #(
  parameter int PRESCALE = 2
) (
  input  wire         clk,
  input  wire         rst,
  input  cmd_addr_t   cmd_addr_i,
  input  cmd_word_t   cmd_data_i,
  input  wire         cmd_rqst_i,
  output logic        cmd_ack_o,
  output cmd_word_t   cmd_resp_o,
  output logic        read_done_o,
  output logic        en_i2c2_o,
  output logic        ready_o,
  output logic        nack_o,
  input  wire         scl_i,
  output logic        scl_o,
  output logic        scl_t,
  input  wire         sda_i,
  output logic        sda_o,
  output logic        sda_t
);

  logic       run;
  logic       tick;
  logic [1:0] quarter;

  i2c_byte_if u_bus ();

  assign nack_o = u_bus.nack;

  i2c_cmd_sequencer u_seq (
    .clk         (clk),
    .rst         (rst),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_rqst_i  (cmd_rqst_i),
    .cmd_ack_o   (cmd_ack_o),
    .cmd_resp_o  (cmd_resp_o),
    .read_done_o (read_done_o),
    .en_i2c2_o   (en_i2c2_o),
    .ready_o     (ready_o),
    .bus         (u_bus.seq)
  );

  i2c_bit_timer #(
    .PRESCALE (PRESCALE)
  ) u_timer (
    .clk       (clk),
    .rst       (rst),
    .run_i     (run),
    .tick_o    (tick),
    .quarter_o (quarter)
  );

  i2c_byte_master u_eng (
    .clk       (clk),
    .rst       (rst),
    .bus       (u_bus.eng),
    .tick_i    (tick),
    .quarter_i (quarter),
    .run_o     (run),
    .scl_i     (scl_i),
    .scl_o     (scl_o),
    .scl_t     (scl_t),
    .sda_i     (sda_i),
    .sda_o     (sda_o),
    .sda_t     (sda_t)
  );

endmodule

`default_nettype wire

// File: verif/i2c_slave_model.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_model #(
  parameter logic [6:0] ADDR_A = 7'h50,
  parameter logic [6:0] ADDR_B = 7'h20
) (
  input  wire  scl_i,
  input  wire  sda_i,
  output logic sda_pull_o
);

  typedef enum logic [1:0] {
    M_IDLE,
    M_ADDR,
    M_WRITE,
    M_READ
  } mode_t;

  logic [7:0] regs [256];
  mode_t      mode;
  logic [7:0] shreg;
  logic [7:0] tx;
  logic [7:0] ptr;
  int         bit_cnt;
  int         wr_count;
  logic       ack_phase;
  logic       got_ptr;
  logic       master_ack;

  initial begin
    int r;
    for (r = 0; r < 256; r++) begin
      regs[r] = r[7:0] ^ 8'h5a;
    end
    mode       = M_IDLE;
    shreg      = 8'h00;
    tx         = 8'hff;
    ptr        = 8'h00;
    bit_cnt    = 0;
    wr_count   = 0;
    ack_phase  = 1'b0;
    got_ptr    = 1'b0;
    master_ack = 1'b0;
    sda_pull_o = 1'b0;
  end

  // Start or repeated start
  always @(negedge sda_i) begin
    if (scl_i === 1'b1) begin
      mode       = M_ADDR;
      bit_cnt    = 0;
      ack_phase  = 1'b0;
      got_ptr    = 1'b0;
      sda_pull_o = 1'b0;
    end
  end

  // Stop
  always @(posedge sda_i) begin
    if (scl_i === 1'b1) begin
      mode       = M_IDLE;
      sda_pull_o = 1'b0;
    end
  end

  always @(posedge scl_i) begin
    if (mode != M_IDLE) begin
      if (ack_phase) begin
        master_ack = (sda_i === 1'b0);
      end else begin
        shreg   = {shreg[6:0], sda_i};
        bit_cnt = bit_cnt + 1;
      end
    end
  end

  always @(negedge scl_i) begin
    if (mode == M_IDLE) begin
      sda_pull_o = 1'b0;
    end else if (ack_phase) begin
      ack_phase  = 1'b0;
      bit_cnt    = 0;
      sda_pull_o = 1'b0;
      if (mode == M_READ) begin
        if (master_ack) begin
          tx         = regs[ptr];
          ptr        = ptr + 8'd1;
          sda_pull_o = !tx[7];
        end else begin
          mode = M_IDLE;
        end
      end
    end else if (bit_cnt == 8) begin
      ack_phase  = 1'b1;
      sda_pull_o = 1'b1;
      case (mode)
        M_ADDR: begin
          if ((shreg[7:1] == ADDR_A) || (shreg[7:1] == ADDR_B)) begin
            mode = shreg[0] ? M_READ : M_WRITE;
          end else begin
            mode       = M_IDLE;
            ack_phase  = 1'b0;
            sda_pull_o = 1'b0;
          end
        end
        M_WRITE: begin
          // First byte after the address sets the register pointer
          if (got_ptr) begin
            regs[ptr] = shreg;
            ptr       = ptr + 8'd1;
            wr_count  = wr_count + 1;
          end else begin
            ptr     = shreg;
            got_ptr = 1'b1;
          end
        end
        default: sda_pull_o = 1'b0;
      endcase
    end else if (mode == M_READ) begin
      sda_pull_o = !tx[7 - bit_cnt];
    end
  end

endmodule

`default_nettype wire

// File: verif/i2c_bus_tb.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_bus_tb;

  localparam int PRESCALE       = 2;
  localparam int ROWS           = 9;
  localparam int TIMEOUT_CYCLES = ROWS * 4 * 36 * (PRESCALE + 1) * 2;

  localparam int K_WRITE = 0;
  localparam int K_READ  = 1;
  localparam int K_QUIET = 2;
  localparam int K_BUSY  = 3;

  logic        clk;
  logic        rst;
  logic [5:0]  cmd_addr;
  logic [31:0] cmd_data;
  logic        cmd_rqst;
  logic        cmd_ack;
  logic [31:0] cmd_resp;
  logic        read_done;
  logic        en_i2c2;
  logic        ready;
  logic        nack;
  logic        scl_o, scl_t, sda_o, sda_t;
  logic        scl_line, sda_line, sda_pull;

  // Stimulus table, one entry per row
  string       t_name   [ROWS];
  int          t_kind   [ROWS];
  logic [5:0]  t_addr   [ROWS];
  logic [31:0] t_word   [ROWS];
  logic [31:0] t_resp   [ROWS];
  logic        t_chk_en [ROWS];
  logic        t_en     [ROWS];
  logic [7:0]  t_reg    [ROWS];
  logic [7:0]  t_val    [ROWS];
  logic        t_chk2   [ROWS];
  logic [7:0]  t_reg2   [ROWS];
  logic [7:0]  t_val2   [ROWS];
  int          t_writes [ROWS];
  logic        t_nack   [ROWS];

  int    row_cnt;
  int    row_errs;
  int    passed;
  int    cycles;
  string cur_name;

  // Released lines float high through the pull-up
  assign scl_line = scl_t ? 1'b1 : scl_o;
  assign sda_line = (sda_t ? 1'b1 : sda_o) & !sda_pull;

  i2c_bus_top #(
    .PRESCALE (PRESCALE)
  ) u_i2c_bus_top (
    .clk         (clk),
    .rst         (rst),
    .cmd_addr_i  (cmd_addr),
    .cmd_data_i  (cmd_data),
    .cmd_rqst_i  (cmd_rqst),
    .cmd_ack_o   (cmd_ack),
    .cmd_resp_o  (cmd_resp),
    .read_done_o (read_done),
    .en_i2c2_o   (en_i2c2),
    .ready_o     (ready),
    .nack_o      (nack),
    .scl_i       (scl_line),
    .scl_o       (scl_o),
    .scl_t       (scl_t),
    .sda_i       (sda_line),
    .sda_o       (sda_o),
    .sda_t       (sda_t)
  );

  i2c_slave_model u_model (
    .scl_i      (scl_line),
    .sda_i      (sda_line),
    .sda_pull_o (sda_pull)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  function automatic logic [7:0] init_byte(input logic [7:0] r);
    return r ^ 8'h5a;
  endfunction

  function automatic logic [31:0] direct_word(input logic rd, input logic [6:0] dev,
                                              input logic [7:0] r, input logic [7:0] v);
    return {7'h03, rd, 1'b0, dev, r, v};
  endfunction

  // Filter select in bits 23..17, antenna in bit 13
  function automatic logic [31:0] filter_word(input logic [6:0] filt, input logic ant);
    return {8'h00, filt, 3'b000, ant, 13'h0000};
  endfunction

  // Same device, next register, inverted value
  function automatic logic [31:0] intruder_word(input logic [31:0] w);
    return {w[31:16], w[15:8] + 8'd1, ~w[7:0]};
  endfunction

  task automatic add_row(input string name, input int kind, input logic [5:0] addr,
                         input logic [31:0] word, input logic [31:0] resp,
                         input logic chk_en, input logic en,
                         input logic [7:0] r, input logic [7:0] v,
                         input logic chk2, input logic [7:0] r2, input logic [7:0] v2,
                         input int writes, input logic nk);
    t_name[row_cnt]   = name;
    t_kind[row_cnt]   = kind;
    t_addr[row_cnt]   = addr;
    t_word[row_cnt]   = word;
    t_resp[row_cnt]   = resp;
    t_chk_en[row_cnt] = chk_en;
    t_en[row_cnt]     = en;
    t_reg[row_cnt]    = r;
    t_val[row_cnt]    = v;
    t_chk2[row_cnt]   = chk2;
    t_reg2[row_cnt]   = r2;
    t_val2[row_cnt]   = v2;
    t_writes[row_cnt] = writes;
    t_nack[row_cnt]   = nk;
    row_cnt++;
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch %s %s: expected 0x%0h, actual 0x%0h", cur_name, what,
               expected, actual);
      row_errs++;
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok) else begin
      $display("%s: %s", cur_name, what);
      row_errs++;
    end
  endtask

  task automatic issue_cmd(input logic [5:0] addr, input logic [31:0] word);
    cmd_addr = addr;
    cmd_data = word;
    cmd_rqst = 1'b1;
    @(negedge clk);
    cmd_rqst = 1'b0;
  endtask

  task automatic run_row(input int i);
    int   writes_before;
    logic ack_bad;
    writes_before = u_model.wr_count;
    ack_bad       = 1'b0;
    issue_cmd(t_addr[i], t_word[i]);
    if (t_kind[i] == K_QUIET) begin
      repeat (8) begin
        if ((ready !== 1'b1) || (cmd_ack !== 1'b1) || (scl_line !== 1'b1)) ack_bad = 1'b1;
        @(negedge clk);
      end
      check_true(!ack_bad, "the bus started for an unchanged filter value");
    end else begin
      while (ready !== 1'b0) @(negedge clk);
      if (t_kind[i] == K_BUSY) begin
        issue_cmd(t_addr[i], intruder_word(t_word[i]));
        check_true(cmd_ack === 1'b0, "cmd_ack_o stayed high after a dropped request");
      end
      if (t_kind[i] == K_READ) begin
        while (read_done !== 1'b1) begin
          if (cmd_ack !== 1'b0) ack_bad = 1'b1;
          @(negedge clk);
        end
        check_value("cmd_resp_o", t_resp[i], cmd_resp);
        check_true(!ack_bad, "cmd_ack_o went high before the read was done");
      end
      while (ready !== 1'b1) @(negedge clk);
    end
    check_value("register", {24'h0, t_val[i]}, {24'h0, u_model.regs[t_reg[i]]});
    if (t_chk2[i]) begin
      check_value("next register", {24'h0, t_val2[i]}, {24'h0, u_model.regs[t_reg2[i]]});
    end
    if (t_chk_en[i]) check_value("en_i2c2_o", {31'h0, t_en[i]}, {31'h0, en_i2c2});
    check_value("write count", t_writes[i], u_model.wr_count - writes_before);
    check_value("nack_o", {31'h0, t_nack[i]}, {31'h0, nack});
  endtask

  initial begin : main
    int          i;
    logic [31:0] rnd;
    logic [6:0]  filt;
    logic        ant;
    rst      = 1'b1;
    cmd_addr = 6'h00;
    cmd_data = 32'h0;
    cmd_rqst = 1'b0;
    row_cnt  = 0;
    passed   = 0;
    rnd      = $urandom(36);
    rnd      = $urandom;
    filt     = rnd[6:0];
    ant      = rnd[7];
    // The filter path starts from all zero after reset
    if ((filt == 7'd0) && !ant) ant = 1'b1;

    add_row("wr_bus1", K_WRITE, 6'h3c, direct_word(1'b0, 7'h50, 8'h10, 8'ha5), 32'h0,
            1'b1, 1'b0, 8'h10, 8'ha5, 1'b0, 8'h00, 8'h00, 1, 1'b0);
    add_row("wr_bus2", K_WRITE, 6'h3d, direct_word(1'b0, 7'h50, 8'h20, 8'h3c), 32'h0,
            1'b1, 1'b1, 8'h20, 8'h3c, 1'b0, 8'h00, 8'h00, 1, 1'b0);
    add_row("rd_fresh", K_READ, 6'h3c, direct_word(1'b1, 7'h50, 8'h40, 8'h00),
            {init_byte(8'h43), init_byte(8'h42), init_byte(8'h41), init_byte(8'h40)},
            1'b1, 1'b0, 8'h40, init_byte(8'h40), 1'b0, 8'h00, 8'h00, 0, 1'b0);
    add_row("rd_written", K_READ, 6'h3d, direct_word(1'b1, 7'h50, 8'h10, 8'h00),
            {init_byte(8'h13), init_byte(8'h12), init_byte(8'h11), 8'ha5},
            1'b1, 1'b1, 8'h10, 8'ha5, 1'b0, 8'h00, 8'h00, 0, 1'b0);
    add_row("filter_new", K_WRITE, 6'h00, filter_word(filt, ant), 32'h0,
            1'b1, 1'b0, 8'h0a, {ant, filt}, 1'b1, 8'h0b, 8'h00, 2, 1'b0);
    add_row("filter_same", K_QUIET, 6'h00, filter_word(filt, ant), 32'h0,
            1'b1, 1'b0, 8'h0a, {ant, filt}, 1'b1, 8'h0b, 8'h00, 0, 1'b0);
    add_row("busy_drop", K_BUSY, 6'h3c, direct_word(1'b0, 7'h50, 8'h60, 8'h77), 32'h0,
            1'b1, 1'b0, 8'h60, 8'h77, 1'b1, 8'h61, init_byte(8'h61), 1, 1'b0);
    add_row("absent_dev", K_WRITE, 6'h3c, direct_word(1'b0, 7'h33, 8'h70, 8'h12), 32'h0,
            1'b1, 1'b0, 8'h70, init_byte(8'h70), 1'b0, 8'h00, 8'h00, 0, 1'b1);
    add_row("after_nack", K_WRITE, 6'h3c, direct_word(1'b0, 7'h20, 8'h30, 8'h5f), 32'h0,
            1'b1, 1'b0, 8'h30, 8'h5f, 1'b0, 8'h00, 8'h00, 1, 1'b0);

    repeat (5) @(negedge clk);
    rst = 1'b0;
    while (ready !== 1'b1) @(negedge clk);

    for (i = 0; i < ROWS; i++) begin
      cur_name = t_name[i];
      row_errs = 0;
      run_row(i);
      if (row_errs == 0) begin
        passed++;
        $display("%s: pass", t_name[i]);
      end else begin
        $display("%s: fail, %0d checks wrong", t_name[i], row_errs);
      end
    end

    $display("rows run %0d, passed %0d, failed %0d", ROWS, passed, ROWS - passed);
    if (passed == ROWS) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
src/i2c_cmd_pkg.sv
src/i2c_bus_pkg.sv
src/i2c_byte_if.sv
src/i2c_cmd_sequencer.sv
src/i2c_bit_timer.sv
src/i2c_byte_master.sv
src/i2c_bus_top.sv
verif/i2c_slave_model.sv
verif/i2c_bus_tb.sv

// File: Bender.yml
package:
  name: i2c_bus

sources:
  - src/i2c_cmd_pkg.sv
  - src/i2c_bus_pkg.sv
  - src/i2c_byte_if.sv
  - src/i2c_cmd_sequencer.sv
  - src/i2c_bit_timer.sv
  - src/i2c_byte_master.sv
  - src/i2c_bus_top.sv
  - target: test
    files:
      - verif/i2c_slave_model.sv
      - verif/i2c_bus_tb.sv
